/* rtl/fifo_defines.svh */
/*
 * Size and threshold constants of the synchronous FIFO subsystem.
 * Included by the package and by every module that sizes a port from them.
 */

`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// ------------------------------------------------------------
// Geometry
// ------------------------------------------------------------
// Entries, must stay a power of two
`define FIFO_DEPTH              16
`define FIFO_DATA_WIDTH         32
// log2 of the depth
`define FIFO_ADDR_WIDTH         4
// One extra bit so a full FIFO fits in the count
`define FIFO_CNT_WIDTH          5

// ------------------------------------------------------------
// Programmable flag levels
// ------------------------------------------------------------
`define FIFO_PROG_FULL_ASSERT   12
`define FIFO_PROG_FULL_NEGATE   10
`define FIFO_PROG_EMPTY_ASSERT  3
`define FIFO_PROG_EMPTY_NEGATE  5

`endif

/* rtl/fifo_pkg.sv */
/*
 * Structs passed between the FIFO blocks and seen by the testbench.
 * Import with fifo_pkg::* in the module header.
 */

`include "fifo_defines.svh"

package fifo_pkg;

   // RAM port control, driven by the pointer logic
   typedef struct packed {
      logic                        we;
      logic                        re;
      logic [`FIFO_ADDR_WIDTH-1:0] waddr;
      logic [`FIFO_ADDR_WIDTH-1:0] raddr;
   } ram_ctl_t;

   // Status word at the subsystem boundary
   // Write side first, read side after
   typedef struct packed {
      logic full;
      logic almost_full;
      logic prog_full;
      logic overflow;
      logic empty;
      logic almost_empty;
      logic prog_empty;
      logic underflow;
   } fifo_status_t;

   // Flags decoded from the count
   typedef struct packed {
      logic almost_full;
      logic almost_empty;
      logic prog_full;
      logic prog_empty;
   } level_flags_t;

endpackage

/* rtl/fifo_sync_ctl.sv */
/*
 * Pointer and occupancy control of the single-clock FIFO.
 * Qualifies the enables, drives the RAM and registers full, empty and the pulses.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_sync_ctl
   import fifo_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       wr_en_i,
   input  logic                       rd_en_i,
   output ram_ctl_t                   ram_ctl_o,
   output logic                       wr_ack_o,
   output logic                       rd_valid_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       overflow_o,
   output logic                       underflow_o,
   output logic [`FIFO_CNT_WIDTH-1:0] datacount_o
);

   logic [`FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
   logic [`FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
   logic [`FIFO_CNT_WIDTH-1:0]  cnt_q;
   logic [`FIFO_CNT_WIDTH-1:0]  cnt_nxt;
   logic                        full_q;
   logic                        empty_q;
   logic                        wr_accept;
   logic                        rd_accept;
   logic                        wr_ack_q;
   logic                        rd_valid_q;
   logic                        overflow_q;
   logic                        underflow_q;

   // ------------------------------------------------------------
   // Access qualification
   // ------------------------------------------------------------
   // Only the registered flags gate an access
   assign wr_accept = wr_en_i & ~full_q;
   assign rd_accept = rd_en_i & ~empty_q;

   // RAM sees the accepting edge itself
   // Read data lands one cycle later, with rd_valid
   assign ram_ctl_o.we    = wr_accept;
   assign ram_ctl_o.re    = rd_accept;
   assign ram_ctl_o.waddr = wr_ptr_q;
   assign ram_ctl_o.raddr = rd_ptr_q;

   // Next occupancy
   always_comb begin
      case ({wr_accept, rd_accept})
         2'b10:   cnt_nxt = cnt_q + 1'b1;
         2'b01:   cnt_nxt = cnt_q - 1'b1;
         // Both or neither, level unchanged
         default: cnt_nxt = cnt_q;
      endcase
   end

   // ------------------------------------------------------------
   // Pointers and count
   // ------------------------------------------------------------
   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_accept) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_accept) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Full and empty from the next count, so no extra cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q   <= '0;
         full_q  <= 1'b0;
         empty_q <= 1'b1;
      end else begin
         cnt_q   <= cnt_nxt;
         full_q  <= (cnt_nxt == `FIFO_DEPTH);
         empty_q <= (cnt_nxt == 0);
      end
   end

   // ------------------------------------------------------------
   // Handshake and error pulses
   // ------------------------------------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ack_q    <= 1'b0;
         rd_valid_q  <= 1'b0;
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         wr_ack_q    <= wr_accept;
         rd_valid_q  <= rd_accept;
         // Rejected accesses, flagged for one cycle
         overflow_q  <= wr_en_i & full_q;
         underflow_q <= rd_en_i & empty_q;
      end
   end

   assign wr_ack_o    = wr_ack_q;
   assign rd_valid_o  = rd_valid_q;
   assign full_o      = full_q;
   assign empty_o     = empty_q;
   assign overflow_o  = overflow_q;
   assign underflow_o = underflow_q;
   assign datacount_o = cnt_q;

endmodule

/* rtl/fifo_level_flags.sv */
/*
 * Level flags derived from the FIFO occupancy count.
 * Almost flags are combinational, programmable flags keep state with hysteresis.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_level_flags
   import fifo_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic [`FIFO_CNT_WIDTH-1:0] datacount_i,
   output level_flags_t               level_o
);

   logic prog_full_q;
   logic prog_empty_q;
   logic almost_full;
   logic almost_empty;

   // ------------------------------------------------------------
   // Almost flags
   // ------------------------------------------------------------
   // One entry away from either end
   assign almost_full  = (datacount_i >= (`FIFO_DEPTH - 1));
   assign almost_empty = (datacount_i <= 1);

   // ------------------------------------------------------------
   // Programmable flags
   // ------------------------------------------------------------
   // Set and clear levels differ
   // A count between them keeps the flag where it was
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prog_full_q <= 1'b0;
      end else begin
         if (datacount_i >= `FIFO_PROG_FULL_ASSERT) begin
            prog_full_q <= 1'b1;
         end else if (datacount_i < `FIFO_PROG_FULL_NEGATE) begin
            prog_full_q <= 1'b0;
         end
      end
   end

   // Mirror image on the empty side
   // Starts set, the FIFO is empty out of reset
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prog_empty_q <= 1'b1;
      end else begin
         if (datacount_i <= `FIFO_PROG_EMPTY_ASSERT) begin
            prog_empty_q <= 1'b1;
         end else if (datacount_i > `FIFO_PROG_EMPTY_NEGATE) begin
            prog_empty_q <= 1'b0;
         end
      end
   end

   assign level_o.almost_full  = almost_full;
   assign level_o.almost_empty = almost_empty;
   assign level_o.prog_full    = prog_full_q;
   assign level_o.prog_empty   = prog_empty_q;

endmodule

/* rtl/fifo_sdp_ram.sv */
/*
 * Simple dual-port storage array of the FIFO, one write and one read port.
 * Read data is registered, so it appears one cycle after the read enable.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_sdp_ram
   import fifo_pkg::*;
(
   input  logic                        clk_i,
   input  ram_ctl_t                    ram_ctl_i,
   input  logic [`FIFO_DATA_WIDTH-1:0] wdata_i,
   output logic [`FIFO_DATA_WIDTH-1:0] rdata_o
);

   // Storage, maps onto block RAM
   logic [`FIFO_DATA_WIDTH-1:0] mem [`FIFO_DEPTH];
   logic [`FIFO_DATA_WIDTH-1:0] rdata_q;

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (ram_ctl_i.we) begin
         mem[ram_ctl_i.waddr] <= wdata_i;
      end
   end

   // ------------------------------------------------------------
   // Read port
   // ------------------------------------------------------------
   // Holds the last word between reads
   always_ff @(posedge clk_i) begin
      if (ram_ctl_i.re) begin
         rdata_q <= mem[ram_ctl_i.raddr];
      end
   end

   assign rdata_o = rdata_q;

endmodule

/* rtl/fifo_wrapper.sv */
/*
 * Top of the synchronous FIFO subsystem.
 * Joins the pointer control, the level flag logic and the RAM, and packs the status word.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_wrapper
   import fifo_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        wr_en_i,
   input  logic [`FIFO_DATA_WIDTH-1:0] wdata_i,
   input  logic                        rd_en_i,
   output logic [`FIFO_DATA_WIDTH-1:0] rdata_o,
   output logic                        rd_valid_o,
   output logic                        wr_ack_o,
   output fifo_status_t                status_o,
   output logic [`FIFO_CNT_WIDTH-1:0]  datacount_o
);

   ram_ctl_t     ram_ctl;
   level_flags_t level;
   logic         full;
   logic         empty;
   logic         overflow;
   logic         underflow;

   // ------------------------------------------------------------
   // Pointers, count and handshake
   // ------------------------------------------------------------
   fifo_sync_ctl fifo_sync_ctl_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .ram_ctl_o   (ram_ctl),
      .wr_ack_o    (wr_ack_o),
      .rd_valid_o  (rd_valid_o),
      .full_o      (full),
      .empty_o     (empty),
      .overflow_o  (overflow),
      .underflow_o (underflow),
      .datacount_o (datacount_o)
   );

   // Flags from the registered count
   fifo_level_flags fifo_level_flags_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .datacount_i (datacount_o),
      .level_o     (level)
   );

   // Storage
   fifo_sdp_ram fifo_sdp_ram_i (
      .clk_i     (clk_i),
      .ram_ctl_i (ram_ctl),
      .wdata_i   (wdata_i),
      .rdata_o   (rdata_o)
   );

   // ------------------------------------------------------------
   // Status word
   // ------------------------------------------------------------
   assign status_o = '{
      full:         full,
      almost_full:  level.almost_full,
      prog_full:    level.prog_full,
      overflow:     overflow,
      empty:        empty,
      almost_empty: level.almost_empty,
      prog_empty:   level.prog_empty,
      underflow:    underflow
   };

endmodule

/* verification/fifo_checker.sv */
/*
 * Concurrent assertions on the FIFO flags and count.
 * Bound into the subsystem top, keeps a count of failed properties.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_checker
   import fifo_pkg::*;
(
   input logic                       clk_i,
   input logic                       arst_n_i,
   input logic                       wr_en_i,
   input logic                       rd_en_i,
   input logic                       wr_ack_o,
   input logic                       rd_valid_o,
   input fifo_status_t               status_o,
   input logic [`FIFO_CNT_WIDTH-1:0] datacount_o
);

   int unsigned fail_cnt = 0;

   // ------------------------------------------------------------
   // Flag and handshake properties
   // ------------------------------------------------------------
   // Full and empty exclude each other
   a_full_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(status_o.full && status_o.empty))
      else begin
         fail_cnt++;
         $error("full and empty are high together");
      end

   // A dropped write is never acknowledged
   a_no_ack_on_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (wr_en_i && status_o.full) |=> !wr_ack_o)
      else begin
         fail_cnt++;
         $error("wr_ack after a write into a full FIFO");
      end

   // Nor is a dropped read
   a_no_valid_on_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rd_en_i && status_o.empty) |=> !rd_valid_o)
      else begin
         fail_cnt++;
         $error("rd_valid after a read from an empty FIFO");
      end

   a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      datacount_o <= `FIFO_DEPTH)
      else begin
         fail_cnt++;
         $error("datacount is above the depth");
      end

endmodule

bind fifo_wrapper fifo_checker fifo_checker_i (
   .clk_i       (clk_i),
   .arst_n_i    (arst_n_i),
   .wr_en_i     (wr_en_i),
   .rd_en_i     (rd_en_i),
   .wr_ack_o    (wr_ack_o),
   .rd_valid_o  (rd_valid_o),
   .status_o    (status_o),
   .datacount_o (datacount_o)
);

/* verification/fifo_tb.sv */
/*
 * Table-driven testbench of the synchronous FIFO subsystem.
 * A queue model predicts every output one cycle after each edge.
 */

`timescale 1ns/1ps

`include "fifo_defines.svh"

module fifo_tb
   import fifo_pkg::*;
();

   // One row of stimulus, held for reps cycles
   typedef struct packed {
      logic       wr;
      logic       rd;
      logic [7:0] reps;
   } stim_row_t;

   localparam int NUM_ROWS = 17;

   logic                        clk_i;
   logic                        arst_n_i;
   logic                        wr_en_i;
   logic                        rd_en_i;
   logic [`FIFO_DATA_WIDTH-1:0] wdata_i;
   logic [`FIFO_DATA_WIDTH-1:0] rdata_o;
   logic                        rd_valid_o;
   logic                        wr_ack_o;
   fifo_status_t                status_o;
   logic [`FIFO_CNT_WIDTH-1:0]  datacount_o;

   // Reference model state
   logic [`FIFO_DATA_WIDTH-1:0] model_q [$];
   logic [`FIFO_DATA_WIDTH-1:0] exp_rdata;
   logic                        exp_wr_ack;
   logic                        exp_rd_valid;
   logic                        exp_ovf;
   logic                        exp_unf;
   logic                        exp_pf;
   logic                        exp_pe;

   int unsigned err_cnt     = 0;
   int unsigned chk_cnt     = 0;
   int unsigned cycle_cnt   = 0;
   int unsigned cycle_limit = 32'hffff_ffff;
   int unsigned total_reps;
   int unsigned asrt_fails;

   // Count trace in the comments on the right
   stim_row_t stim_tbl [NUM_ROWS] = '{
      '{1'b1, 1'b0, 8'd16},   // Fill from 0 to 16
      '{1'b1, 1'b0, 8'd3},    // Overflow at full
      '{1'b0, 1'b1, 8'd16},   // Drain from 16 to 0
      '{1'b0, 1'b1, 8'd3},    // Underflow at empty
      '{1'b1, 1'b0, 8'd8},    // Up to mid level 8
      '{1'b1, 1'b1, 8'd10},   // Simultaneous access holds 8
      '{1'b1, 1'b0, 8'd4},    // 8 to 12
      '{1'b0, 1'b1, 8'd2},    // 12 to 10
      '{1'b1, 1'b0, 8'd2},    // 10 to 12
      '{1'b0, 1'b1, 8'd2},    // 12 to 10
      '{1'b1, 1'b0, 8'd2},    // 10 to 12
      '{1'b0, 1'b1, 8'd9},    // 12 to 3
      '{1'b1, 1'b0, 8'd2},    // 3 to 5
      '{1'b0, 1'b1, 8'd2},    // 5 to 3
      '{1'b1, 1'b0, 8'd2},    // 3 to 5
      '{1'b0, 1'b1, 8'd5},    // 5 to 0
      '{1'b0, 1'b0, 8'd4}     // Idle while pulses settle
   };

   fifo_wrapper fifo_wrapper_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .wr_en_i     (wr_en_i),
      .wdata_i     (wdata_i),
      .rd_en_i     (rd_en_i),
      .rdata_o     (rdata_o),
      .rd_valid_o  (rd_valid_o),
      .wr_ack_o    (wr_ack_o),
      .status_o    (status_o),
      .datacount_o (datacount_o)
   );

   // ------------------------------------------------------------
   // Clock and run limit
   // ------------------------------------------------------------
   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("Testbench failed");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Model and comparison
   // ------------------------------------------------------------
   // Advance the model by one edge with the inputs now applied
   task automatic update_model();
      int unsigned cnt_pre;
      logic        wr_acc;
      logic        rd_acc;
      cnt_pre = model_q.size();
      wr_acc  = wr_en_i && (cnt_pre != `FIFO_DEPTH);
      rd_acc  = rd_en_i && (cnt_pre != 0);
      // Programmable flags look at the count before the edge
      if (cnt_pre >= `FIFO_PROG_FULL_ASSERT) exp_pf = 1'b1;
      else if (cnt_pre < `FIFO_PROG_FULL_NEGATE) exp_pf = 1'b0;
      if (cnt_pre <= `FIFO_PROG_EMPTY_ASSERT) exp_pe = 1'b1;
      else if (cnt_pre > `FIFO_PROG_EMPTY_NEGATE) exp_pe = 1'b0;
      exp_ovf      = wr_en_i && (cnt_pre == `FIFO_DEPTH);
      exp_unf      = rd_en_i && (cnt_pre == 0);
      exp_wr_ack   = wr_acc;
      exp_rd_valid = rd_acc;
      if (rd_acc) exp_rdata = model_q.pop_front();
      if (wr_acc) model_q.push_back(wdata_i);
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic check_outputs();
      fifo_status_t exp_status;
      exp_status.full         = (model_q.size() == `FIFO_DEPTH);
      exp_status.almost_full  = (model_q.size() >= `FIFO_DEPTH - 1);
      exp_status.prog_full    = exp_pf;
      exp_status.overflow     = exp_ovf;
      exp_status.empty        = (model_q.size() == 0);
      exp_status.almost_empty = (model_q.size() <= 1);
      exp_status.prog_empty   = exp_pe;
      exp_status.underflow    = exp_unf;
      compare_value("status", status_o, exp_status);
      compare_value("datacount", datacount_o, model_q.size());
      compare_value("wr_ack", wr_ack_o, exp_wr_ack);
      compare_value("rd_valid", rd_valid_o, exp_rd_valid);
      // Read data only matters with rd_valid
      if (exp_rd_valid) compare_value("rdata", rdata_o, exp_rdata);
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      clk_i        = 1'b0;
      arst_n_i     = 1'b0;
      wr_en_i      = 1'b0;
      rd_en_i      = 1'b0;
      wdata_i      = '0;
      exp_rdata    = '0;
      exp_wr_ack   = 1'b0;
      exp_rd_valid = 1'b0;
      exp_ovf      = 1'b0;
      exp_unf      = 1'b0;
      exp_pf       = 1'b0;
      exp_pe       = 1'b1;
      void'($urandom(32'h29e45374));
      total_reps = 0;
      foreach (stim_tbl[i]) total_reps += stim_tbl[i].reps;
      cycle_limit = total_reps + 50;

      repeat (10) @(posedge clk_i);
      #1 arst_n_i = 1'b1;
      // Reset values before the first edge
      check_outputs();

      foreach (stim_tbl[i]) begin
         for (int r = 0; r < stim_tbl[i].reps; r++) begin
            wr_en_i = stim_tbl[i].wr;
            rd_en_i = stim_tbl[i].rd;
            wdata_i = $urandom;
            @(posedge clk_i);
            #1;
            update_model();
            check_outputs();
         end
      end
      wr_en_i = 1'b0;
      rd_en_i = 1'b0;

      asrt_fails = fifo_wrapper_i.fifo_checker_i.fail_cnt;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               chk_cnt, err_cnt, asrt_fails);
      if (err_cnt == 0 && asrt_fails == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+rtl
rtl/fifo_pkg.sv
rtl/fifo_sync_ctl.sv
rtl/fifo_level_flags.sv
rtl/fifo_sdp_ram.sv
rtl/fifo_wrapper.sv
verification/fifo_checker.sv
verification/fifo_tb.sv

/* Bender.yml */
package:
  name: fifo_subsystem

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/fifo_pkg.sv
      - rtl/fifo_sync_ctl.sv
      - rtl/fifo_level_flags.sv
      - rtl/fifo_sdp_ram.sv
      - rtl/fifo_wrapper.sv
  - target: simulation
    files:
      - verification/fifo_checker.sv
      - verification/fifo_tb.sv
